//--- Bender.yml
package:
  name: issue_backend

sources:
  - files:
      - verilog/isa_pkg.sv
      - verilog/core_pkg.sv
      - verilog/instr_decoder.sv
      - verilog/issue_queue.sv
      - verilog/exec_unit.sv
      - verilog/reorder_buffer.sv
      - verilog/issue_backend.sv
  - target: test
    files:
      - tests/issue_backend_tb.sv

//--- issue_backend.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/instr_decoder.sv
verilog/issue_queue.sv
verilog/exec_unit.sv
verilog/reorder_buffer.sv
verilog/issue_backend.sv
tests/issue_backend_tb.sv

//--- tests/issue_backend_tb.sv
module issue_backend_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_reg = 19;
    localparam int n_imm = 11;
    localparam int n_dep = 20;
    localparam int n_nop = 16;
    localparam int n_hold = 40;
    localparam int n_rand = 300;
    localparam int watchdog_cycles = 200 * (n_reg + n_imm + n_dep + n_nop + n_hold + n_rand + 1);
    localparam int mode_on = 0;
    localparam int mode_hold = 1;
    localparam int mode_random = 2;

    logic                      clk;
    logic                      rst;
    logic                      instr_valid;
    logic                      instr_ready;
    logic [isa_pkg::xlen-1:0]  instr;
    logic                      commit_valid;
    logic                      commit_ready;
    logic [isa_pkg::reg_w-1:0] commit_rd;
    logic [isa_pkg::xlen-1:0]  commit_value;

    logic [isa_pkg::xlen-1:0]  model_rf[core_pkg::num_regs];
    logic [isa_pkg::reg_w-1:0] exp_rd_q[$];
    logic [isa_pkg::xlen-1:0]  exp_val_q[$];
    logic                      exp_avail;
    logic [isa_pkg::reg_w-1:0] exp_rd;
    logic [isa_pkg::xlen-1:0]  exp_value;
    int                        sent_count;
    int                        commit_count;
    int                        ready_mode;
    string                     test_name;

    issue_backend u_issue_backend (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    always #2 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] encode_word(input logic [4:0] op, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2,
                                                input logic [11:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    function automatic logic [31:0] ref_alu(input logic [2:0] f, input logic [31:0] a,
                                            input logic [31:0] b);
        case (f)
            isa_pkg::op_add: return a + b;
            isa_pkg::op_sub: return a - b;
            isa_pkg::op_and: return a & b;
            isa_pkg::op_or:  return a | b;
            isa_pkg::op_xor: return a ^ b;
            isa_pkg::op_sll: return a << b[4:0];
            isa_pkg::op_srl: return a >> b[4:0];
            default:         return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic void refresh_expected();
        exp_avail = (exp_rd_q.size() != 0);
        if (exp_avail) begin
            exp_rd = exp_rd_q[0];
            exp_value = exp_val_q[0];
        end
    endfunction

    // Sequential reference: every non-nop word in program order
    task automatic model_apply(input logic [31:0] w);
        logic [4:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        op = w[31:27];
        if (!op[4]) begin
            a = (w[21:17] == 0) ? 32'd0 : model_rf[w[21:17]];
            b = op[3] ? {{20{w[11]}}, w[11:0]} : ((w[16:12] == 0) ? 32'd0 : model_rf[w[16:12]]);
            res = ref_alu(op[2:0], a, b);
            if (w[26:22] != 0) model_rf[w[26:22]] = res;
            exp_rd_q.push_back(w[26:22]);
            exp_val_q.push_back(res);
            sent_count++;
            refresh_expected();
        end
    endtask

    function automatic logic [31:0] random_word(input bit allow_nop);
        logic [4:0] op;
        op = 5'($urandom_range(15, 0));
        if (allow_nop && $urandom_range(7, 0) == 0) op = 5'($urandom_range(31, 16));
        return encode_word(op, 5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)),
                           5'($urandom_range(7, 0)), 12'($urandom));
    endfunction

    // Called on a falling edge; returns on the falling edge after the transfer
    task automatic send_word(input logic [31:0] w, input int gap_max);
        int gap;
        gap = (gap_max > 0) ? $urandom_range(gap_max, 0) : 0;
        repeat (gap) begin
            instr_valid = 1'b0;
            @(negedge clk);
        end
        instr = w;
        instr_valid = 1'b1;
        while (!instr_ready) @(negedge clk);
        model_apply(w);
        @(negedge clk);
    endtask

    task automatic wait_drain();
        instr_valid = 1'b0;
        while (exp_rd_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    always @(negedge clk) begin
        case (ready_mode)
            mode_hold:   commit_ready = 1'b0;
            mode_random: commit_ready = ($urandom_range(3, 0) != 0);
            default:     commit_ready = 1'b1;
        endcase
    end

    // Count every commit handshake and retire its expected entry
    always @(posedge clk) begin
        if (rst && commit_valid && commit_ready) begin
            commit_count++;
            if (exp_rd_q.size() != 0) begin
                void'(exp_rd_q.pop_front());
                void'(exp_val_q.pop_front());
                refresh_expected();
            end
        end
    end

    a_commit_expected: assert property (@(posedge clk) disable iff (!rst)
        (commit_valid && commit_ready) |-> exp_avail)
        else fail_now($sformatf("commit of rd %0d arrived with no result outstanding in %s",
                                $sampled(commit_rd), test_name));

    a_commit_data: assert property (@(posedge clk) disable iff (!rst)
        (commit_valid && commit_ready && exp_avail) |->
            (commit_rd == exp_rd && commit_value == exp_value))
        else fail_now($sformatf("error %s: expected rd %0d value %08h, actual rd %0d value %08h",
                                test_name, $sampled(exp_rd), $sampled(exp_value),
                                $sampled(commit_rd), $sampled(commit_value)));

    a_commit_stable: assert property (@(posedge clk) disable iff (!rst)
        (commit_valid && !commit_ready) |=>
            (commit_valid && $stable(commit_rd) && $stable(commit_value)))
        else fail_now($sformatf("commit output changed before it was accepted in %s", test_name));

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        fail_now("timeout, commits stopped before all words were retired");
    end

    initial begin
        logic [11:0] imm_list[8];
        void'($urandom(32'h30a2_850b));
        clk = 1'b0;
        rst = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        commit_ready = 1'b1;
        ready_mode = mode_on;
        sent_count = 0;
        commit_count = 0;
        test_name = "reset";
        exp_avail = 1'b0;
        exp_rd = '0;
        exp_value = '0;
        for (int i = 0; i < core_pkg::num_regs; i++) model_rf[i] = '0;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        assert (instr_ready && !commit_valid)
            else fail_now("DUT not idle after reset");

        test_name = "reg_ops";
        send_word(encode_word(5'd8, 5'd1, 5'd0, 5'd0, 12'h123), 0);
        send_word(encode_word(5'd8, 5'd2, 5'd0, 5'd0, 12'hffb), 0);  // -5
        send_word(encode_word(5'd8, 5'd3, 5'd0, 5'd0, 12'h004), 0);
        for (int f = 0; f < 8; f++) begin
            send_word(encode_word(5'(f), 5'(8 + f), 5'd1, 5'd2, 12'h000), 0);
            send_word(encode_word(5'(f), 5'(16 + f), 5'd2, 5'd3, 12'h000), 0);
        end
        wait_drain();

        test_name = "imm_ops";
        imm_list = '{12'h800, 12'hfff, 12'h0f0, 12'h7ff, 12'habc, 12'h01f, 12'h003, 12'hffa};
        for (int f = 0; f < 8; f++) begin
            send_word(encode_word(5'(8 + f), 5'(8 + f), 5'd2, 5'd0, imm_list[f]), 0);
        end
        send_word(encode_word(5'd8, 5'd0, 5'd1, 5'd0, 12'h055), 0);  // Write to r0 is dropped
        send_word(encode_word(5'd0, 5'd5, 5'd0, 5'd0, 12'h000), 0);
        send_word(encode_word(5'd8, 5'd6, 5'd0, 5'd0, 12'h001), 0);
        wait_drain();

        test_name = "dep_chain";
        for (int i = 0; i < 10; i++) send_word(encode_word(5'd8, 5'd1, 5'd1, 5'd0, 12'h001), 0);
        for (int i = 0; i < 8; i++) send_word(encode_word(5'd0, 5'd2, 5'd2, 5'd1, 12'h000), 0);
        send_word(encode_word(5'd1, 5'd3, 5'd2, 5'd1, 12'h000), 0);
        send_word(encode_word(5'd4, 5'd4, 5'd3, 5'd2, 12'h000), 0);
        wait_drain();

        test_name = "nop_drop";
        for (int i = 0; i < n_nop; i++) begin
            if (i % 4 == 0) send_word(encode_word(isa_pkg::op_nop, 5'd7, 5'd7, 5'd0, 12'h001), 0);
            else if (i % 2 == 0) send_word(encode_word(5'(16 + i), 5'd7, 5'd1, 5'd2, 12'h0), 0);
            else send_word(encode_word(5'd8, 5'd7, 5'd7, 5'd0, 12'(i)), 0);
        end
        wait_drain();

        test_name = "backpressure";
        ready_mode = mode_hold;
        fork
            for (int i = 0; i < n_hold; i++) send_word(random_word(1'b0), 0);
            begin
                repeat (80) @(negedge clk);
                assert (!instr_ready)
                    else fail_now("instr_ready stayed high while commits were held off");
                ready_mode = mode_on;
            end
        join
        wait_drain();

        test_name = "random";
        ready_mode = mode_random;
        for (int i = 0; i < n_rand; i++) send_word(random_word(1'b1), 3);
        wait_drain();
        ready_mode = mode_on;

        test_name = "commit_count";
        if (commit_count == sent_count && exp_rd_q.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_now($sformatf("error %s: expected %0d commits, actual %0d",
                               test_name, sent_count, commit_count));
        end
    end

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

    // Architectural register count
    localparam int num_regs = 32;

    // Entries in the issue queue
    localparam int iq_depth_default = 8;

    // Entries in the reorder buffer, one tag each
    localparam int rob_depth_default = 8;

endpackage

//--- verilog/exec_unit.sv
module exec_unit #(
    parameter int ROB_DEPTH = core_pkg::rob_depth_default
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issue_fire,
    input  logic [isa_pkg::op_w-1:0]      iss_op,
    input  logic [isa_pkg::reg_w-1:0]     iss_rs1,
    input  logic [isa_pkg::reg_w-1:0]     iss_rs2,
    input  logic [isa_pkg::xlen-1:0]      iss_imm,
    input  logic                          iss_has_imm,
    input  logic [$clog2(ROB_DEPTH)-1:0]  iss_tag,
    output logic                          wb_valid,
    output logic [$clog2(ROB_DEPTH)-1:0]  wb_tag,
    output logic [isa_pkg::xlen-1:0]      wb_value,
    input  logic                          rf_we,
    input  logic [isa_pkg::reg_w-1:0]     rf_waddr,
    input  logic [isa_pkg::xlen-1:0]      rf_wdata
);

    localparam int n_regs = 2 ** isa_pkg::reg_w;
    localparam int shamt_w = $clog2(isa_pkg::xlen);

    logic [isa_pkg::xlen-1:0]    rf[n_regs];
    logic [isa_pkg::xlen-1:0]    opa;
    logic [isa_pkg::xlen-1:0]    opb;
    logic [isa_pkg::xlen-1:0]    alu_out;
    logic [isa_pkg::funct_w-1:0] funct;
    logic [shamt_w-1:0]          shamt;

    // Register zero is hardwired
    assign opa = (iss_rs1 == '0) ? '0 : rf[iss_rs1];
    assign opb = iss_has_imm ? iss_imm : ((iss_rs2 == '0) ? '0 : rf[iss_rs2]);
    assign funct = iss_op[isa_pkg::funct_w-1:0];
    assign shamt = opb[shamt_w-1:0];

    always_comb begin
        case (funct)
            isa_pkg::op_add: alu_out = opa + opb;
            isa_pkg::op_sub: alu_out = opa - opb;
            isa_pkg::op_and: alu_out = opa & opb;
            isa_pkg::op_or:  alu_out = opa | opb;
            isa_pkg::op_xor: alu_out = opa ^ opb;
            isa_pkg::op_sll: alu_out = opa << shamt;
            isa_pkg::op_srl: alu_out = opa >> shamt;
            default:         alu_out = {{(isa_pkg::xlen - 1){1'b0}}, $signed(opa) < $signed(opb)};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < n_regs; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we && rf_waddr != '0) begin
            rf[rf_waddr] <= rf_wdata;  // Commit write from the ROB
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= issue_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            wb_tag <= iss_tag;
            wb_value <= alu_out;
        end
    end

endmodule

//--- verilog/instr_decoder.sv
module instr_decoder (
    input  logic [isa_pkg::xlen-1:0]  instr,
    output logic [isa_pkg::op_w-1:0]  op,
    output logic [isa_pkg::reg_w-1:0] rd,
    output logic [isa_pkg::reg_w-1:0] rs1,
    output logic [isa_pkg::reg_w-1:0] rs2,
    output logic [isa_pkg::xlen-1:0]  imm,
    output logic                      has_imm,
    output logic                      is_nop
);

    logic [isa_pkg::imm_w-1:0] imm_field;

    always_comb begin
        op = instr[isa_pkg::op_lsb +: isa_pkg::op_w];
        rd = instr[isa_pkg::rd_lsb +: isa_pkg::reg_w];
        rs1 = instr[isa_pkg::rs1_lsb +: isa_pkg::reg_w];
        rs2 = instr[isa_pkg::rs2_lsb +: isa_pkg::reg_w];
        imm_field = instr[isa_pkg::imm_lsb +: isa_pkg::imm_w];
    end

    // Sign extension of the 12-bit immediate
    assign imm = {{(isa_pkg::xlen - isa_pkg::imm_w){imm_field[isa_pkg::imm_w-1]}}, imm_field};

    assign has_imm = op[isa_pkg::imm_bit];

    // Bit 4 marks the all-ones no-op and every unused high code
    assign is_nop = op[isa_pkg::nop_bit];

endmodule

//--- verilog/isa_pkg.sv
package isa_pkg;

    localparam int xlen = 32;
    localparam int op_w = 5;
    localparam int reg_w = 5;
    localparam int imm_w = 12;
    localparam int funct_w = 3;  // Low bits of the operation field

    // Field positions, counted from the low end of the word
    localparam int op_lsb = 27;
    localparam int rd_lsb = 22;
    localparam int rs1_lsb = 17;
    localparam int rs2_lsb = 12;
    localparam int imm_lsb = 0;

    // Flag bits inside the operation field
    localparam int imm_bit = 3;  // Immediate replaces rs2
    localparam int nop_bit = 4;  // Reserved codes, all treated as no-op

    // ALU functions
    localparam logic [funct_w-1:0] op_add = 3'd0;
    localparam logic [funct_w-1:0] op_sub = 3'd1;
    localparam logic [funct_w-1:0] op_and = 3'd2;
    localparam logic [funct_w-1:0] op_or = 3'd3;
    localparam logic [funct_w-1:0] op_xor = 3'd4;
    localparam logic [funct_w-1:0] op_sll = 3'd5;
    localparam logic [funct_w-1:0] op_srl = 3'd6;
    localparam logic [funct_w-1:0] op_slt = 3'd7;

    localparam logic [op_w-1:0] op_nop = 5'b11111;

endpackage

//--- verilog/issue_backend.sv
module issue_backend #(
    parameter int IQ_DEPTH = core_pkg::iq_depth_default,
    parameter int ROB_DEPTH = core_pkg::rob_depth_default
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    output logic                      instr_ready,
    input  logic [isa_pkg::xlen-1:0]  instr,
    output logic                      commit_valid,
    input  logic                      commit_ready,
    output logic [isa_pkg::reg_w-1:0] commit_rd,
    output logic [isa_pkg::xlen-1:0]  commit_value
);

    localparam int tag_w = $clog2(ROB_DEPTH);

    // Decoded word
    logic [isa_pkg::op_w-1:0]  dec_op;
    logic [isa_pkg::reg_w-1:0] dec_rd, dec_rs1, dec_rs2;
    logic [isa_pkg::xlen-1:0]  dec_imm;
    logic                      dec_has_imm;
    logic                      dec_is_nop;

    // Queue head and hazard handshake
    logic [isa_pkg::reg_w-1:0] head_rs1, head_rs2;
    logic                      head_uses_rs2;
    logic                      src_busy;
    logic                      rob_full;
    logic                      issue_fire;
    logic [isa_pkg::op_w-1:0]  iss_op;
    logic [isa_pkg::reg_w-1:0] iss_rs1, iss_rs2, iss_rd;
    logic [isa_pkg::xlen-1:0]  iss_imm;
    logic                      iss_has_imm;
    logic [tag_w-1:0]          alloc_tag;

    // Writeback and commit write
    logic                      wb_valid;
    logic [tag_w-1:0]          wb_tag;
    logic [isa_pkg::xlen-1:0]  wb_value;
    logic                      rf_we;
    logic [isa_pkg::reg_w-1:0] rf_waddr;
    logic [isa_pkg::xlen-1:0]  rf_wdata;

    instr_decoder u_instr_decoder (
        .instr   (instr),
        .op      (dec_op),
        .rd      (dec_rd),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .imm     (dec_imm),
        .has_imm (dec_has_imm),
        .is_nop  (dec_is_nop)
    );

    issue_queue #(
        .DEPTH (IQ_DEPTH)
    ) u_issue_queue (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (instr_valid),
        .in_ready      (instr_ready),
        .in_op         (dec_op),
        .in_rs1        (dec_rs1),
        .in_rs2        (dec_rs2),
        .in_rd         (dec_rd),
        .in_imm        (dec_imm),
        .in_has_imm    (dec_has_imm),
        .in_is_nop     (dec_is_nop),
        .head_rs1      (head_rs1),
        .head_rs2      (head_rs2),
        .head_uses_rs2 (head_uses_rs2),
        .rob_full      (rob_full),
        .src_busy      (src_busy),
        .issue_fire    (issue_fire),
        .iss_op        (iss_op),
        .iss_rs1       (iss_rs1),
        .iss_rs2       (iss_rs2),
        .iss_rd        (iss_rd),
        .iss_imm       (iss_imm),
        .iss_has_imm   (iss_has_imm)
    );

    exec_unit #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_exec_unit (
        .clk         (clk),
        .rst         (rst),
        .issue_fire  (issue_fire),
        .iss_op      (iss_op),
        .iss_rs1     (iss_rs1),
        .iss_rs2     (iss_rs2),
        .iss_imm     (iss_imm),
        .iss_has_imm (iss_has_imm),
        .iss_tag     (alloc_tag),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .wb_value    (wb_value),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata)
    );

    reorder_buffer #(
        .DEPTH (ROB_DEPTH)
    ) u_reorder_buffer (
        .clk           (clk),
        .rst           (rst),
        .issue_fire    (issue_fire),
        .iss_rd        (iss_rd),
        .alloc_tag     (alloc_tag),
        .head_rs1      (head_rs1),
        .head_rs2      (head_rs2),
        .head_uses_rs2 (head_uses_rs2),
        .src_busy      (src_busy),
        .rob_full      (rob_full),
        .wb_valid      (wb_valid),
        .wb_tag        (wb_tag),
        .wb_value      (wb_value),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit_rd     (commit_rd),
        .commit_value  (commit_value),
        .rf_we         (rf_we),
        .rf_waddr      (rf_waddr),
        .rf_wdata      (rf_wdata)
    );

endmodule

//--- verilog/issue_queue.sv
module issue_queue #(
    parameter int DEPTH = core_pkg::iq_depth_default
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [isa_pkg::op_w-1:0]  in_op,
    input  logic [isa_pkg::reg_w-1:0] in_rs1,
    input  logic [isa_pkg::reg_w-1:0] in_rs2,
    input  logic [isa_pkg::reg_w-1:0] in_rd,
    input  logic [isa_pkg::xlen-1:0]  in_imm,
    input  logic                      in_has_imm,
    input  logic                      in_is_nop,
    output logic [isa_pkg::reg_w-1:0] head_rs1,
    output logic [isa_pkg::reg_w-1:0] head_rs2,
    output logic                      head_uses_rs2,
    input  logic                      rob_full,
    input  logic                      src_busy,
    output logic                      issue_fire,
    output logic [isa_pkg::op_w-1:0]  iss_op,
    output logic [isa_pkg::reg_w-1:0] iss_rs1,
    output logic [isa_pkg::reg_w-1:0] iss_rs2,
    output logic [isa_pkg::reg_w-1:0] iss_rd,
    output logic [isa_pkg::xlen-1:0]  iss_imm,
    output logic                      iss_has_imm
);

    localparam int ptr_w = $clog2(DEPTH);
    localparam int cnt_w = $clog2(DEPTH + 1);

    logic [isa_pkg::op_w-1:0]  op_q[DEPTH];
    logic [isa_pkg::reg_w-1:0] rs1_q[DEPTH];
    logic [isa_pkg::reg_w-1:0] rs2_q[DEPTH];
    logic [isa_pkg::reg_w-1:0] rd_q[DEPTH];
    logic [isa_pkg::xlen-1:0]  imm_q[DEPTH];
    logic                      has_imm_q[DEPTH];
    logic [ptr_w-1:0]          head;
    logic [ptr_w-1:0]          tail;
    logic [cnt_w-1:0]          count;
    logic                      push;

    assign in_ready = (count < DEPTH);  // Issue in the same cycle frees nothing yet
    assign push = in_valid && in_ready && !in_is_nop;
    assign issue_fire = (count != '0) && !rob_full && !src_busy;

    // Head entry, seen both by the hazard check and the execute unit
    assign head_rs1 = rs1_q[head];
    assign head_rs2 = rs2_q[head];
    assign head_uses_rs2 = !has_imm_q[head];
    assign iss_op = op_q[head];
    assign iss_rs1 = rs1_q[head];
    assign iss_rs2 = rs2_q[head];
    assign iss_rd = rd_q[head];
    assign iss_imm = imm_q[head];
    assign iss_has_imm = has_imm_q[head];

    always_ff @(posedge clk) begin
        if (push) begin
            op_q[tail] <= in_op;
            rs1_q[tail] <= in_rs1;
            rs2_q[tail] <= in_rs2;
            rd_q[tail] <= in_rd;
            imm_q[tail] <= in_imm;
            has_imm_q[tail] <= in_has_imm;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == ptr_w'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (issue_fire) begin
                head <= (head == ptr_w'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({push, issue_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- verilog/reorder_buffer.sv
module reorder_buffer #(
    parameter int DEPTH = core_pkg::rob_depth_default
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_fire,
    input  logic [isa_pkg::reg_w-1:0] iss_rd,
    output logic [$clog2(DEPTH)-1:0]  alloc_tag,
    input  logic [isa_pkg::reg_w-1:0] head_rs1,
    input  logic [isa_pkg::reg_w-1:0] head_rs2,
    input  logic                      head_uses_rs2,
    output logic                      src_busy,
    output logic                      rob_full,
    input  logic                      wb_valid,
    input  logic [$clog2(DEPTH)-1:0]  wb_tag,
    input  logic [isa_pkg::xlen-1:0]  wb_value,
    output logic                      commit_valid,
    input  logic                      commit_ready,
    output logic [isa_pkg::reg_w-1:0] commit_rd,
    output logic [isa_pkg::xlen-1:0]  commit_value,
    output logic                      rf_we,
    output logic [isa_pkg::reg_w-1:0] rf_waddr,
    output logic [isa_pkg::xlen-1:0]  rf_wdata
);

    localparam int tag_w = $clog2(DEPTH);
    localparam int cnt_w = $clog2(DEPTH + 1);

    logic [isa_pkg::reg_w-1:0] rd_r[DEPTH];
    logic [isa_pkg::xlen-1:0]  val_r[DEPTH];
    logic                      valid_r[DEPTH];
    logic                      done_r[DEPTH];
    logic [tag_w-1:0]          head;
    logic [tag_w-1:0]          tail;
    logic [cnt_w-1:0]          count;
    logic                      commit;

    assign alloc_tag = tail;
    assign rob_full = (count == DEPTH);

    // Any in-flight writer of a source register holds the queue head
    always_comb begin
        src_busy = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (valid_r[i] && rd_r[i] != '0) begin
                if (rd_r[i] == head_rs1 || (head_uses_rs2 && rd_r[i] == head_rs2)) begin
                    src_busy = 1'b1;
                end
            end
        end
    end

    assign commit_valid = valid_r[head] && done_r[head];
    assign commit_rd = rd_r[head];
    assign commit_value = val_r[head];
    assign commit = commit_valid && commit_ready;

    assign rf_we = commit && (commit_rd != '0);
    assign rf_waddr = commit_rd;
    assign rf_wdata = commit_value;

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            rd_r[tail] <= iss_rd;
        end
        if (wb_valid) begin
            val_r[wb_tag] <= wb_value;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_r[i] <= 1'b0;
                done_r[i] <= 1'b0;
            end
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (wb_valid) begin
                done_r[wb_tag] <= 1'b1;
            end
            // Issue is held off while full, so tail never meets a retiring head
            if (issue_fire) begin
                valid_r[tail] <= 1'b1;
                done_r[tail] <= 1'b0;
                tail <= (tail == tag_w'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (commit) begin
                valid_r[head] <= 1'b0;
                done_r[head] <= 1'b0;
                head <= (head == tag_w'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({issue_fire, commit})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule
